/* hdl/datapath_defines.svh */
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Word and register file geometry
`define WORD_WIDTH   32
`define REG_COUNT    16
`define SELECT_WIDTH 5

// Request word bit positions above the general registers
// Bits 0 to 15 request R0 to R15
`define REQ_HI     16
`define REQ_LO     17
`define REQ_ZHIGH  18
`define REQ_ZLOW   19
`define REQ_PC     20
`define REQ_MDR    21
`define REQ_INPORT 22
`define REQ_C      23

`endif

/* hdl/datapath_pkg.sv */
package datapathPkg;

    // ALU operation codes as they appear on the operation port
    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opShr = 5'b00111,
        opShl = 5'b01000,
        opRor = 5'b01001,
        opRol = 5'b01010,
        opMul = 5'b01111,
        opDiv = 5'b10000,
        opNeg = 5'b10001,
        opNot = 5'b10010
    } aluOp;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } rFormFields;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] constant;
    } iFormFields;

    // The same IR word seen as register format or immediate format
    typedef union packed {
        rFormFields rForm;
        iFormFields iForm;
    } instrWord;

endpackage

/* hdl/bus_link_if.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

interface busLink;

    logic [`WORD_WIDTH-1:0]   busData;
    logic [`SELECT_WIDTH-1:0] selectCode;
    logic                     selectValid;
    logic                     multipleRequest;

    modport encoder (
        output busData,
        output selectCode,
        output selectValid,
        output multipleRequest
    );

    // Sources watch the decoded select to decide whether they own the bus
    modport source (
        input busData,
        input selectCode,
        input selectValid,
        input multipleRequest
    );

endinterface

/* hdl/general_registers.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module generalRegisters (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`REG_COUNT-1:0]  loadStrobes,
    busLink.source                 link,
    output logic [`WORD_WIDTH-1:0] sourceWord
);

    localparam int IndexWidth = $clog2(`REG_COUNT);

    logic [`WORD_WIDTH-1:0] regFile [`REG_COUNT];
    logic                   ownsBus;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            // Several strobes may be high together and all of them load the same bus word
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (loadStrobes[i]) begin
                    regFile[i] <= link.busData;
                end
            end
        end
    end

    // Codes 0 to 15 map directly onto R0 to R15
    assign ownsBus = link.selectValid && (link.selectCode < `REG_COUNT);

    always_comb begin
        sourceWord = '0;
        if (ownsBus) begin
            sourceWord = regFile[link.selectCode[IndexWidth-1:0]];
        end
    end

endmodule

/* hdl/special_registers.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module specialRegisters (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic                   PCin,
    input  logic                   IncPC,
    input  logic                   IRin,
    input  logic                   MARin,
    input  logic                   MDRin,
    input  logic                   Read,
    input  logic                   HIin,
    input  logic                   LOin,
    input  logic [`WORD_WIDTH-1:0] Mdatain,
    input  logic [`WORD_WIDTH-1:0] inPortData,
    busLink.source                 link,
    output logic [`WORD_WIDTH-1:0] sourceWord,
    output logic [`WORD_WIDTH-1:0] marAddress
);

    logic [`WORD_WIDTH-1:0] pc;
    logic [`WORD_WIDTH-1:0] mar;
    logic [`WORD_WIDTH-1:0] mdr;
    logic [`WORD_WIDTH-1:0] hi;
    logic [`WORD_WIDTH-1:0] lo;
    logic [`WORD_WIDTH-1:0] constWord;
    datapathPkg::instrWord  ir;

    // The constant field is 19 bits and sign-extends to a full word
    assign constWord = `WORD_WIDTH'($signed(ir.iForm.constant));
    assign marAddress = mar;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            hi  <= '0;
            lo  <= '0;
        end else begin
            // Increment wins over a bus load of PC
            if (IncPC) begin
                pc <= pc + 1'b1;
            end else if (PCin) begin
                pc <= link.busData;
            end
            if (IRin) begin
                ir <= link.busData;
            end
            if (MARin) begin
                mar <= link.busData;
            end
            if (MDRin) begin
                mdr <= Read ? Mdatain : link.busData;
            end
            if (HIin) begin
                hi <= link.busData;
            end
            if (LOin) begin
                lo <= link.busData;
            end
        end
    end

    always_comb begin
        sourceWord = '0;
        if (link.selectValid) begin
            case (link.selectCode)
                `REQ_HI:     sourceWord = hi;
                `REQ_LO:     sourceWord = lo;
                `REQ_PC:     sourceWord = pc;
                `REQ_MDR:    sourceWord = mdr;
                `REQ_INPORT: sourceWord = inPortData;
                `REQ_C:      sourceWord = constWord;
                default:     sourceWord = '0;
            endcase
        end
    end

    // A read cycle that does not land in MDR must not also redirect PC twice
    pcStepCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (Read && !MDRin) |-> !(PCin && IncPC))
        else $error("PCin and IncPC both high in a read step without MDRin");

endmodule

/* hdl/alu_unit.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module aluUnit (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic                   Yin,
    input  logic                   Zlowin,
    input  logic                   Zhighin,
    input  datapathPkg::aluOp      operation,
    busLink.source                 link,
    output logic [`WORD_WIDTH-1:0] sourceWord
);

    logic [`WORD_WIDTH-1:0]          y;
    logic [`WORD_WIDTH-1:0]          b;
    logic [`WORD_WIDTH-1:0]          zLow;
    logic [`WORD_WIDTH-1:0]          zHigh;
    logic [4:0]                      shiftAmount;
    logic [2*`WORD_WIDTH-1:0]        rotRight;
    logic [2*`WORD_WIDTH-1:0]        rotLeft;
    logic signed [2*`WORD_WIDTH-1:0] product;
    logic signed [`WORD_WIDTH-1:0]   quotient;
    logic signed [`WORD_WIDTH-1:0]   remainder;
    logic [2*`WORD_WIDTH-1:0]        result;

    // Operand A is always Y, operand B is whatever is on the bus this cycle
    assign b = link.busData;
    assign shiftAmount = b[4:0];
    assign rotRight = {y, y} >> shiftAmount;
    assign rotLeft = {y, y} << shiftAmount;
    assign product = $signed(y) * $signed(b);
    assign quotient = $signed(y) / $signed(b);
    assign remainder = $signed(y) % $signed(b);

    always_comb begin
        result = '0;
        case (operation)
            datapathPkg::opAdd: result[`WORD_WIDTH-1:0] = y + b;
            datapathPkg::opSub: result[`WORD_WIDTH-1:0] = y - b;
            datapathPkg::opAnd: result[`WORD_WIDTH-1:0] = y & b;
            datapathPkg::opOr:  result[`WORD_WIDTH-1:0] = y | b;
            datapathPkg::opShr: result[`WORD_WIDTH-1:0] = y >> shiftAmount;
            datapathPkg::opShl: result[`WORD_WIDTH-1:0] = y << shiftAmount;
            datapathPkg::opRor: result[`WORD_WIDTH-1:0] = rotRight[`WORD_WIDTH-1:0];
            datapathPkg::opRol: result[`WORD_WIDTH-1:0] = rotLeft[2*`WORD_WIDTH-1:`WORD_WIDTH];
            datapathPkg::opMul: result = product;
            datapathPkg::opDiv: result = {remainder, quotient};
            datapathPkg::opNeg: result[`WORD_WIDTH-1:0] = '0 - b;
            datapathPkg::opNot: result[`WORD_WIDTH-1:0] = ~b;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            y     <= '0;
            zLow  <= '0;
            zHigh <= '0;
        end else begin
            if (Yin) begin
                y <= b;
            end
            if (Zlowin) begin
                zLow <= result[`WORD_WIDTH-1:0];
            end
            if (Zhighin) begin
                zHigh <= result[2*`WORD_WIDTH-1:`WORD_WIDTH];
            end
        end
    end

    always_comb begin
        sourceWord = '0;
        if (link.selectValid && link.selectCode == `REQ_ZHIGH) begin
            sourceWord = zHigh;
        end else if (link.selectValid && link.selectCode == `REQ_ZLOW) begin
            sourceWord = zLow;
        end
    end

    // The divisor comes over the bus from another block, so it is checked where Z captures it
    divisorCheck: assert property (@(posedge Clock) disable iff (!rstN)
        ((Zlowin || Zhighin) && operation == datapathPkg::opDiv) |-> (b != '0))
        else $error("Division captured into Z with a zero divisor");

    opcodeCheck: assert property (@(posedge Clock) disable iff (!rstN)
        Zlowin |-> operation inside {datapathPkg::opAdd, datapathPkg::opSub,
            datapathPkg::opAnd, datapathPkg::opOr, datapathPkg::opShr,
            datapathPkg::opShl, datapathPkg::opRor, datapathPkg::opRol,
            datapathPkg::opMul, datapathPkg::opDiv, datapathPkg::opNeg,
            datapathPkg::opNot})
        else $error("Illegal ALU operation code %b captured into ZLow", operation);

endmodule

/* hdl/bus_encoder.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module busEncoder (
    input  logic [`WORD_WIDTH-1:0] encoderInput,
    input  logic [`WORD_WIDTH-1:0] generalWord,
    input  logic [`WORD_WIDTH-1:0] specialWord,
    input  logic [`WORD_WIDTH-1:0] aluWord,
    busLink.encoder                link
);

    logic [`SELECT_WIDTH-1:0] lowestIndex;

    // Scanning downward leaves the lowest set bit as the winner
    always_comb begin
        lowestIndex = '0;
        for (int i = `WORD_WIDTH - 1; i >= 0; i--) begin
            if (encoderInput[i]) begin
                lowestIndex = `SELECT_WIDTH'(i);
            end
        end
    end

    assign link.selectCode = lowestIndex;
    assign link.selectValid = |encoderInput;
    assign link.multipleRequest = (encoderInput & (encoderInput - 1'b1)) != '0;

    // Only one source answers any code and the rest return zero, so OR is a mux here
    assign link.busData = generalWord | specialWord | aluWord;

    always_comb begin
        if (link.selectValid) begin
            contentionCheck: assert #0 (!link.multipleRequest)
                else $warning("Several bus requests in %h, source %0d drives the bus",
                              encoderInput, link.selectCode);
        end
    end

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module datapath (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`WORD_WIDTH-1:0] encoderInput,
    input  logic [`REG_COUNT-1:0]  generalIn,
    input  logic                   PCin,
    input  logic                   IncPC,
    input  logic                   IRin,
    input  logic                   MARin,
    input  logic                   MDRin,
    input  logic                   Read,
    input  logic                   HIin,
    input  logic                   LOin,
    input  logic                   Yin,
    input  logic                   Zlowin,
    input  logic                   Zhighin,
    input  logic [4:0]             operation,
    input  logic [`WORD_WIDTH-1:0] Mdatain,
    input  logic [`WORD_WIDTH-1:0] inPortData,
    output logic [`WORD_WIDTH-1:0] busData,
    output logic [`WORD_WIDTH-1:0] marAddress
);

    logic [`WORD_WIDTH-1:0] generalWord;
    logic [`WORD_WIDTH-1:0] specialWord;
    logic [`WORD_WIDTH-1:0] aluWord;

    busLink link ();

    generalRegisters generalRegs (
        .Clock(Clock),
        .rstN(rstN),
        .loadStrobes(generalIn),
        .link(link.source),
        .sourceWord(generalWord)
    );

    specialRegisters specialRegs (
        .Clock(Clock),
        .rstN(rstN),
        .PCin(PCin),
        .IncPC(IncPC),
        .IRin(IRin),
        .MARin(MARin),
        .MDRin(MDRin),
        .Read(Read),
        .HIin(HIin),
        .LOin(LOin),
        .Mdatain(Mdatain),
        .inPortData(inPortData),
        .link(link.source),
        .sourceWord(specialWord),
        .marAddress(marAddress)
    );

    aluUnit alu (
        .Clock(Clock),
        .rstN(rstN),
        .Yin(Yin),
        .Zlowin(Zlowin),
        .Zhighin(Zhighin),
        .operation(datapathPkg::aluOp'(operation)),
        .link(link.source),
        .sourceWord(aluWord)
    );

    busEncoder encoder (
        .encoderInput(encoderInput),
        .generalWord(generalWord),
        .specialWord(specialWord),
        .aluWord(aluWord),
        .link(link.encoder)
    );

    assign busData = link.busData;

endmodule

/* verification/datapath_checker.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module datapathChecker (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`WORD_WIDTH-1:0] encoderInput,
    input  logic [`REG_COUNT-1:0]  generalIn,
    input  logic                   PCin,
    input  logic                   IncPC,
    input  logic                   IRin,
    input  logic                   MARin,
    input  logic                   MDRin,
    input  logic                   Read,
    input  logic                   HIin,
    input  logic                   LOin,
    input  logic                   Yin,
    input  logic                   Zlowin,
    input  logic                   Zhighin,
    input  logic [4:0]             operation,
    input  logic [`WORD_WIDTH-1:0] Mdatain,
    input  logic [`WORD_WIDTH-1:0] inPortData,
    input  logic [`WORD_WIDTH-1:0] busData,
    input  logic [`WORD_WIDTH-1:0] marAddress,
    output int                     errorCount
);

    logic [31:0] gpr [`REG_COUNT];
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] mar;
    logic [31:0] mdr;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] y;
    logic [31:0] zLow;
    logic [31:0] zHigh;
    logic [31:0] expectedBus;
    logic [63:0] aluResult;
    int          errors = 0;

    assign errorCount = errors;

    function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0]         amount;
        logic signed [63:0] wideA;
        logic signed [63:0] wideB;
        logic signed [31:0] quot;
        logic signed [31:0] rem;
        logic [63:0]        result;
        amount = b[4:0];
        wideA = {{32{a[31]}}, a};
        wideB = {{32{b[31]}}, b};
        result = '0;
        case (op)
            datapathPkg::opAdd: result[31:0] = a + b;
            datapathPkg::opSub: result[31:0] = a - b;
            datapathPkg::opAnd: result[31:0] = a & b;
            datapathPkg::opOr:  result[31:0] = a | b;
            datapathPkg::opShr: result[31:0] = a >> amount;
            datapathPkg::opShl: result[31:0] = a << amount;
            datapathPkg::opRor: result[31:0] = (a >> amount) | (a << (6'd32 - amount));
            datapathPkg::opRol: result[31:0] = (a << amount) | (a >> (6'd32 - amount));
            datapathPkg::opMul: result = wideA * wideB;
            datapathPkg::opDiv: begin
                quot = $signed(a) / $signed(b);
                rem = $signed(a) % $signed(b);
                result = {rem, quot};
            end
            datapathPkg::opNeg: result[31:0] = 32'd0 - b;
            datapathPkg::opNot: result[31:0] = ~b;
            default:            result = '0;
        endcase
        aluModel = result;
    endfunction

    // The lowest set request bit picks the source
    function automatic logic [31:0] busModel(input logic [31:0] request);
        int winner;
        winner = -1;
        for (int i = 0; i < 32 && winner < 0; i++) begin
            if (request[i]) begin
                winner = i;
            end
        end
        busModel = '0;
        if (winner >= 0 && winner < `REG_COUNT) begin
            busModel = gpr[winner];
        end else begin
            case (winner)
                `REQ_HI:     busModel = hi;
                `REQ_LO:     busModel = lo;
                `REQ_ZHIGH:  busModel = zHigh;
                `REQ_ZLOW:   busModel = zLow;
                `REQ_PC:     busModel = pc;
                `REQ_MDR:    busModel = mdr;
                `REQ_INPORT: busModel = inPortData;
                `REQ_C:      busModel = {{13{ir[18]}}, ir[18:0]};
                default:     busModel = '0;
            endcase
        end
    endfunction

    always @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                gpr[i] = '0;
            end
            pc = '0;
            ir = '0;
            mar = '0;
            mdr = '0;
            hi = '0;
            lo = '0;
            y = '0;
            zLow = '0;
            zHigh = '0;
        end else begin
            expectedBus = busModel(encoderInput);
            aluResult = aluModel(operation, y, expectedBus);
            if (busData !== expectedBus) begin
                errors++;
                $display("ERROR busData: got %h, expected %h at %0t", busData, expectedBus, $time);
            end
            if (marAddress !== mar) begin
                errors++;
                $display("ERROR marAddress: got %h, expected %h at %0t", marAddress, mar, $time);
            end
            // shadow registers take this edge's loads
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (generalIn[i]) begin
                    gpr[i] = expectedBus;
                end
            end
            if (IncPC) begin
                pc = pc + 1;
            end else if (PCin) begin
                pc = expectedBus;
            end
            if (IRin) begin
                ir = expectedBus;
            end
            if (MARin) begin
                mar = expectedBus;
            end
            if (MDRin) begin
                mdr = Read ? Mdatain : expectedBus;
            end
            if (HIin) begin
                hi = expectedBus;
            end
            if (LOin) begin
                lo = expectedBus;
            end
            if (Yin) begin
                y = expectedBus;
            end
            if (Zlowin) begin
                zLow = aluResult[31:0];
            end
            if (Zhighin) begin
                zHigh = aluResult[63:32];
            end
        end
    end

endmodule

/* verification/datapath_tb.sv */
`timescale 1ns/1ps

`include "datapath_defines.svh"

module datapathTb;

    localparam int EdgeTimeoutNs = 40;

    logic                   Clock;
    logic                   rstN;
    logic [`WORD_WIDTH-1:0] encoderInput;
    logic [`REG_COUNT-1:0]  generalIn;
    logic                   PCin;
    logic                   IncPC;
    logic                   IRin;
    logic                   MARin;
    logic                   MDRin;
    logic                   Read;
    logic                   HIin;
    logic                   LOin;
    logic                   Yin;
    logic                   Zlowin;
    logic                   Zhighin;
    logic [4:0]             operation;
    logic [`WORD_WIDTH-1:0] Mdatain;
    logic [`WORD_WIDTH-1:0] inPortData;
    logic [`WORD_WIDTH-1:0] busData;
    logic [`WORD_WIDTH-1:0] marAddress;
    int                     mismatchCount;
    int                     readErrors;
    int                     seed;
    logic [4:0]             opList [12];
    logic [4:0]             op;
    logic [`WORD_WIDTH-1:0] value;
    logic [`WORD_WIDTH-1:0] operandA;
    logic [`WORD_WIDTH-1:0] operandB;

    datapath dut_i (.*);

    datapathChecker scoreboard (.*, .errorCount(mismatchCount));

    always #4 Clock = ~Clock;

    function automatic logic [`WORD_WIDTH-1:0] requestBit(input int index);
        requestBit = '0;
        requestBit[index] = 1'b1;
    endfunction

    task automatic waitEdge(input bit rising);
        bit arrived;
        bit expired;
        arrived = 1'b0;
        expired = 1'b0;
        while (!arrived && !expired) begin
            fork
                begin
                    if (rising) begin
                        @(posedge Clock);
                    end else begin
                        @(negedge Clock);
                    end
                    arrived = 1'b1;
                end
                begin
                    #(EdgeTimeoutNs);
                    expired = 1'b1;
                end
            join_any
            disable fork;
        end
        if (!arrived) begin
            $display("Timeout: the clock showed no edge for %0d ns", EdgeTimeoutNs);
            $display("Errors: %0d in checker, %0d in readback, plus a timeout",
                     mismatchCount, readErrors);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic expectValue(input string signal, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            readErrors++;
            $display("ERROR %s: got %h, expected %h", signal, got, expected);
        end
    endtask

    task automatic clearStrobes;
        encoderInput = '0;
        generalIn = '0;
        PCin = 1'b0;
        IncPC = 1'b0;
        IRin = 1'b0;
        MARin = 1'b0;
        MDRin = 1'b0;
        Read = 1'b0;
        HIin = 1'b0;
        LOin = 1'b0;
        Yin = 1'b0;
        Zlowin = 1'b0;
        Zhighin = 1'b0;
    endtask

    // Strobes set on a falling edge act at the following rising edge
    task automatic step;
        waitEdge(1'b1);
        waitEdge(1'b0);
        clearStrobes();
    endtask

    task automatic loadMdr(input logic [31:0] data);
        Mdatain = data;
        Read = 1'b1;
        MDRin = 1'b1;
        step();
    endtask

    task automatic moveToGeneral(input int source, input int target);
        encoderInput = requestBit(source);
        generalIn[target] = 1'b1;
        step();
    endtask

    task automatic loadIr(input logic [31:0] word);
        loadMdr(word);
        encoderInput = requestBit(`REQ_MDR);
        IRin = 1'b1;
        step();
    endtask

    task automatic showSource(input int source);
        encoderInput = requestBit(source);
        step();
    endtask

    task automatic expectBus(input logic [31:0] request, input logic [31:0] expected,
                             input string name);
        encoderInput = request;
        waitEdge(1'b1);
        expectValue($sformatf("busData (%s)", name), busData, expected);
        waitEdge(1'b0);
        clearStrobes();
    endtask

    // Y takes A, R1 takes B, and both halves of Z capture the result
    task automatic captureZ(input logic [4:0] code, input logic [31:0] a, input logic [31:0] b);
        loadMdr(a);
        encoderInput = requestBit(`REQ_MDR);
        Yin = 1'b1;
        step();
        loadMdr(b);
        moveToGeneral(`REQ_MDR, 1);
        encoderInput = requestBit(1);
        operation = code;
        Zlowin = 1'b1;
        Zhighin = 1'b1;
        step();
    endtask

    task automatic aluToHiLo(input logic [4:0] code, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] expHi, input logic [31:0] expLo);
        captureZ(code, a, b);
        encoderInput = requestBit(`REQ_ZHIGH);
        HIin = 1'b1;
        step();
        encoderInput = requestBit(`REQ_ZLOW);
        LOin = 1'b1;
        step();
        expectBus(requestBit(`REQ_HI), expHi, "HI");
        expectBus(requestBit(`REQ_LO), expLo, "LO");
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        seed = 32'h97c7;
        readErrors = 0;
        Mdatain = '0;
        inPortData = '0;
        operation = datapathPkg::opAdd;
        clearStrobes();
        opList = '{datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd,
                   datapathPkg::opOr, datapathPkg::opShr, datapathPkg::opShl,
                   datapathPkg::opRor, datapathPkg::opRol, datapathPkg::opMul,
                   datapathPkg::opDiv, datapathPkg::opNeg, datapathPkg::opNot};
        for (int i = 0; i < 4; i++) begin
            waitEdge(1'b0);
        end
        rstN = 1'b1;

        for (int i = 0; i <= `REQ_C; i++) begin
            expectBus(requestBit(i), '0, $sformatf("source %0d after reset", i));
        end
        expectBus('0, '0, "no request");
        inPortData = $random(seed);
        showSource(`REQ_INPORT);

        // One word from memory walks through every general register
        value = $random(seed);
        loadMdr(value);
        moveToGeneral(`REQ_MDR, 0);
        for (int i = 1; i < `REG_COUNT; i++) begin
            moveToGeneral(i - 1, i);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            expectBus(requestBit(i), value, $sformatf("R%0d", i));
        end

        loadMdr(32'h22);
        moveToGeneral(`REQ_MDR, 0);
        loadMdr(32'h10);
        encoderInput = requestBit(`REQ_MDR);
        PCin = 1'b1;
        step();
        // The fetch loads MAR from PC while PC steps on
        encoderInput = requestBit(`REQ_PC);
        MARin = 1'b1;
        IncPC = 1'b1;
        step();
        expectValue("marAddress", marAddress, 32'h10);
        loadIr(32'h2A2B8000);
        expectBus(requestBit(`REQ_PC), 32'h11, "PC after fetch");
        encoderInput = requestBit(0);
        operation = datapathPkg::opNeg;
        Zlowin = 1'b1;
        step();
        moveToGeneral(`REQ_ZLOW, 5);
        expectBus(requestBit(5), 32'hFFFFFFDE, "R5 after neg");

        for (int n = 0; n < 100; n++) begin
            operandA = $random(seed);
            operandB = $random(seed);
            op = opList[$unsigned($random(seed)) % 12];
            // A zero divisor or an overflowing quotient becomes an add
            if (op == datapathPkg::opDiv &&
                (operandB == '0 || (operandA == 32'h80000000 && operandB == '1))) begin
                op = datapathPkg::opAdd;
            end
            captureZ(op, operandA, operandB);
            showSource(`REQ_ZLOW);
            showSource(`REQ_ZHIGH);
        end

        aluToHiLo(datapathPkg::opMul, 32'hFFFFFFFD, 32'd7, 32'hFFFFFFFF, 32'hFFFFFFEB);
        aluToHiLo(datapathPkg::opDiv, 32'hFFFFFFE9, 32'd5, 32'hFFFFFFFD, 32'hFFFFFFFC);
        loadMdr(32'h100);
        encoderInput = requestBit(`REQ_MDR);
        PCin = 1'b1;
        step();
        IncPC = 1'b1;
        step();
        expectBus(requestBit(`REQ_PC), 32'h101, "PC after IncPC");
        encoderInput = requestBit(`REQ_MDR);
        PCin = 1'b1;
        IncPC = 1'b1;
        step();
        expectBus(requestBit(`REQ_PC), 32'h102, "PC after IncPC with PCin");

        loadIr(32'h10000123);
        expectBus(requestBit(`REQ_C), 32'h00000123, "positive constant");
        loadIr(32'h1807FFF0);
        expectBus(requestBit(`REQ_C), 32'hFFFFFFF0, "negative constant");
        loadMdr(32'h5A5A1234);
        moveToGeneral(`REQ_MDR, 3);
        expectBus(requestBit(3) | requestBit(`REQ_HI), 32'h5A5A1234, "R3 over HI");
        expectBus(requestBit(`REQ_LO) | requestBit(`REQ_C), 32'hFFFFFFFC, "LO over C");

        $display("Run complete: %0d checker errors, %0d readback errors",
                 mismatchCount, readErrors);
        if (mismatchCount == 0 && readErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* datapath.f */
+incdir+hdl
hdl/datapath_pkg.sv
hdl/bus_link_if.sv
hdl/general_registers.sv
hdl/special_registers.sv
hdl/alu_unit.sv
hdl/bus_encoder.sv
hdl/datapath.sv
verification/datapath_checker.sv
verification/datapath_tb.sv
